/* src/cube_pkg.sv */
`default_nettype none

package cube_pkg;

    localparam int color_w         = 3;
    localparam int sticker_count   = 54;
    localparam int face_count      = 6;
    localparam int cycles_per_face = 5;
    localparam int cycle_len       = 4;

    typedef logic [color_w-1:0] color_t;

    // stickers 0..23 corners, 24..47 edges, 48..53 centers
    typedef logic [sticker_count*color_w-1:0] cube_state_t;

    typedef logic [5:0] sticker_idx_t;

    // per face, rows follow move order R U F L B D
    // each group of four is a clockwise cycle, sticker at slot k moves to slot k+1
    // groups: two side corner rings, side edge ring, face corner ring, face edge ring
    localparam sticker_idx_t face_cycles [face_count][cycles_per_face*cycle_len] = '{
        '{
            10,  2, 18, 22,
            11,  3, 19, 23,
            32, 27, 42, 47,
            13, 12, 15, 14,
            37, 36, 39, 38
        },
        '{
             8,  7, 18, 13,
            11,  6, 17, 12,
            35, 30, 43, 36,
             0,  3,  2,  1,
            24, 27, 26, 25
        },
        '{
             1, 13, 23,  5,
             2, 14, 20,  6,
            29, 26, 37, 46,
             8, 11, 10,  9,
            34, 35, 32, 33
        },
        '{
             0,  8, 20, 16,
             1,  9, 21, 17,
            25, 34, 45, 40,
             4,  7,  6,  5,
            28, 31, 30, 29
        },
        '{
             0,  4, 22, 12,
             3,  7, 21, 15,
            24, 31, 44, 39,
            18, 17, 16, 19,
            40, 41, 42, 43
        },
        '{
             9, 14, 19,  4,
            10, 15, 16,  5,
            33, 38, 41, 28,
            20, 23, 22, 21,
            44, 45, 46, 47
        }
    };

endpackage

`default_nettype wire

/* src/move_pkg.sv */
`default_nettype none

package move_pkg;

    localparam int move_w     = 4;
    localparam int move_count = 50;

    // codes 1, 14 and 15 are unnamed and behave like mv_nop
    typedef enum logic [move_w-1:0] {
        mv_nop = 4'd0,
        mv_r   = 4'd2,
        mv_ri,
        mv_u,
        mv_ui,
        mv_f,
        mv_fi,
        mv_l,
        mv_li,
        mv_b,
        mv_bi,
        mv_d,
        mv_di
    } move_t;

    // first move in the top nibble
    typedef logic [move_count*move_w-1:0] move_list_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_moving,
        seq_done
    } seq_state_t;

endpackage

`default_nettype wire

/* src/move_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module move_sequencer (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 new_moves_ready,
    input  move_pkg::move_list_t moves_input,
    output logic                 load,
    output logic                 turn_en,
    output logic                 finish,
    output move_pkg::move_t      cur_move
);
    import move_pkg::*;

    seq_state_t state;
    logic [5:0] move_idx;
    move_list_t moves_q;
    logic       last_move;

    // job accepted only while idle
    assign load    = (state == seq_idle) && new_moves_ready;
    assign turn_en = (state == seq_moving);
    assign finish  = (state == seq_done);

    assign cur_move  = move_t'(moves_q[$bits(move_list_t)-1 -: move_w]);
    assign last_move = (move_idx == 6'(move_count - 1));

    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= seq_idle;
            move_idx <= '0;
        end else begin
            case (state)
                seq_idle: begin
                    move_idx <= '0;
                    if (new_moves_ready) begin
                        state <= seq_moving;
                    end
                end
                seq_moving: begin
                    move_idx <= move_idx + 6'd1;
                    if (last_move) begin
                        state <= seq_done;
                    end
                end
                seq_done: begin
                    state <= seq_idle;
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

    // move list shifts up one nibble per applied turn
    always_ff @(posedge clock) begin
        if (load) begin
            moves_q <= moves_input;
        end else if (turn_en) begin
            moves_q <= moves_q << move_w;
        end
    end

endmodule

`default_nettype wire

/* src/cube_turner.sv */
`timescale 1ns/1ps
`default_nettype none

module cube_turner (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  load,
    input  logic                  turn_en,
    input  logic                  finish,
    input  move_pkg::move_t       cur_move,
    input  cube_pkg::cube_state_t cubestate_input,
    output cube_pkg::cube_state_t cubestate_updated,
    output logic                  state_updated
);
    import cube_pkg::*;
    import move_pkg::*;

    cube_state_t cube_q;
    cube_state_t cube_turned;

    // one quarter turn, a pure sticker permutation
    function automatic cube_state_t turn_cube(input cube_state_t cube, input move_t mv);
        cube_state_t result;
        logic [3:0]  code;
        logic [2:0]  face;
        logic        valid;
        logic        inverse;
        int          src;
        int          dst;
        color_t      sticker;
        result  = cube;
        code    = 4'(mv);
        valid   = (mv >= mv_r) && (mv <= mv_di);
        face    = 3'((code - 4'd2) >> 1);
        // odd codes are the inverse turns
        inverse = code[0];
        for (int f = 0; f < face_count; f++) begin
            if (valid && face == 3'(f)) begin
                for (int c = 0; c < cycles_per_face; c++) begin
                    for (int k = 0; k < cycle_len; k++) begin
                        if (inverse) begin
                            src = face_cycles[f][c*cycle_len + (k + 1) % cycle_len];
                            dst = face_cycles[f][c*cycle_len + k];
                        end else begin
                            src = face_cycles[f][c*cycle_len + k];
                            dst = face_cycles[f][c*cycle_len + (k + 1) % cycle_len];
                        end
                        sticker = cube[src*color_w +: color_w];
                        result[dst*color_w +: color_w] = sticker;
                    end
                end
            end
        end
        return result;
    endfunction

    assign cube_turned = turn_cube(cube_q, cur_move);

    // working cube
    always_ff @(posedge clock) begin
        if (load) begin
            cube_q <= cubestate_input;
        end else if (turn_en) begin
            cube_q <= cube_turned;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            cubestate_updated <= '0;
            state_updated     <= 1'b0;
        end else begin
            state_updated <= finish;
            if (finish) begin
                cubestate_updated <= cube_q;
            end
        end
    end

endmodule

`default_nettype wire

/* src/cube_move_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module cube_move_engine (
    input  logic                  clock,
    input  logic                  rst,
    input  move_pkg::move_list_t  moves_input,
    input  logic                  new_moves_ready,
    input  cube_pkg::cube_state_t cubestate_input,
    output cube_pkg::cube_state_t cubestate_updated,
    output logic                  state_updated
);
    import move_pkg::*;

    logic  load;
    logic  turn_en;
    logic  finish;
    move_t cur_move;

    move_sequencer u_sequencer (
        .clock           (clock),
        .rst             (rst),
        .new_moves_ready (new_moves_ready),
        .moves_input     (moves_input),
        .load            (load),
        .turn_en         (turn_en),
        .finish          (finish),
        .cur_move        (cur_move)
    );

    // result appears one cycle after finish
    cube_turner u_turner (
        .clock             (clock),
        .rst               (rst),
        .load              (load),
        .turn_en           (turn_en),
        .finish            (finish),
        .cur_move          (cur_move),
        .cubestate_input   (cubestate_input),
        .cubestate_updated (cubestate_updated),
        .state_updated     (state_updated)
    );

endmodule

`default_nettype wire

/* test/cube_move_engine_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module cube_move_engine_properties (
    input logic                  clock,
    input logic                  rst,
    input logic                  new_moves_ready,
    input logic                  load,
    input cube_pkg::cube_state_t cubestate_input,
    input cube_pkg::cube_state_t cubestate_updated,
    input logic                  state_updated
);
    import cube_pkg::*;

    localparam int center_lsb = 48 * color_w;
    localparam int cube_msb   = sticker_count * color_w - 1;

    logic [cube_msb:center_lsb] centers_q;
    logic [5:0]                 busy_cnt;

    // centers of the last accepted cube
    always_ff @(posedge clock) begin
        if (rst) begin
            centers_q <= '0;
        end else if (load) begin
            centers_q <= cubestate_input[cube_msb:center_lsb];
        end
    end

    // edges left before the engine may take the next job
    always_ff @(posedge clock) begin
        if (rst) begin
            busy_cnt <= '0;
        end else if (load) begin
            busy_cnt <= 6'd51;
        end else if (busy_cnt != 6'd0) begin
            busy_cnt <= busy_cnt - 6'd1;
        end
    end

    a_single_pulse: assert property (@(posedge clock) disable iff (rst)
        state_updated |=> !state_updated)
        else $error("state_updated high in two consecutive cycles");

    a_busy_strobe: assert property (@(posedge clock) disable iff (rst)
        new_moves_ready && (busy_cnt != 6'd0) |-> !load)
        else $error("strobe accepted while a job was running");

    // each done pulse comes 52 edges after an accepted job
    a_pulse_source: assert property (@(posedge clock) disable iff (rst)
        state_updated |-> $past(load, 52))
        else $error("done pulse without a matching accepted job");

    a_centers_fixed: assert property (@(posedge clock) disable iff (rst)
        state_updated |-> cubestate_updated[cube_msb:center_lsb] == centers_q)
        else $error("center stickers differ from the accepted cube");

endmodule

bind cube_move_engine cube_move_engine_properties u_properties (
    .clock             (clock),
    .rst               (rst),
    .new_moves_ready   (new_moves_ready),
    .load              (load),
    .cubestate_input   (cubestate_input),
    .cubestate_updated (cubestate_updated),
    .state_updated     (state_updated)
);

`default_nettype wire

/* test/tb_cube_move_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cube_move_engine;
    import cube_pkg::*;
    import move_pkg::*;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 4;
    localparam int job_cycles   = 60;

    logic        clock;
    logic        rst;
    move_list_t  moves_input;
    logic        new_moves_ready;
    cube_state_t cubestate_input;
    cube_state_t cubestate_updated;
    logic        state_updated;

    integer      seed;
    int          n_rows;
    bit          table_ready;
    cube_state_t last_result;

    // stimulus table, one entry per job
    move_list_t  tab_moves [$];
    bit          tab_random [$];
    bit          tab_identity [$];

    // move codes of the row being built
    logic [3:0]  seq_q [$];

    cube_move_engine i_dut (
        .clock             (clock),
        .rst               (rst),
        .moves_input       (moves_input),
        .new_moves_ready   (new_moves_ready),
        .cubestate_input   (cubestate_input),
        .cubestate_updated (cubestate_updated),
        .state_updated     (state_updated)
    );

    always #(clk_period / 2) clock = ~clock;

    task automatic check_cube(input string name, input cube_state_t expected,
                              input cube_state_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "cube state mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "control bit mismatch");
        end
    endtask

    function automatic cube_state_t random_cube();
        cube_state_t cube;
        logic [31:0] r;
        for (int i = 0; i < sticker_count; i++) begin
            r = $random(seed);
            cube[i*color_w +: color_w] = r[color_w-1:0];
        end
        return cube;
    endfunction

    function automatic cube_state_t pattern_cube();
        cube_state_t cube;
        for (int i = 0; i < sticker_count; i++) begin
            cube[i*color_w +: color_w] = color_t'((i * 5 + i / 7) % 8);
        end
        return cube;
    endfunction

    function automatic move_list_t random_moves();
        move_list_t  list;
        logic [31:0] r;
        for (int i = 0; i < move_count; i++) begin
            r = $random(seed);
            list[$bits(move_list_t)-1 - move_w*i -: move_w] = r[3:0];
        end
        return list;
    endfunction

    // unused slots stay at code 0
    function automatic move_list_t pack_moves();
        move_list_t list;
        list = '0;
        foreach (seq_q[i]) begin
            if (i < move_count) begin
                list[$bits(move_list_t)-1 - move_w*i -: move_w] = seq_q[i];
            end
        end
        return list;
    endfunction

    // clockwise carries each sticker one slot on along its cycle, inverse one slot back
    function automatic cube_state_t turn_reference(input cube_state_t cube,
                                                   input logic [3:0] code);
        cube_state_t next;
        int          f;
        int          a;
        int          b;
        next = cube;
        if (code >= 4'd2 && code <= 4'd13) begin
            f = int'(code >> 1) - 1;
            for (int c = 0; c < cycles_per_face; c++) begin
                for (int k = 0; k < cycle_len; k++) begin
                    a = int'(face_cycles[f][c*cycle_len + k]);
                    b = int'(face_cycles[f][c*cycle_len + (k + 1) % cycle_len]);
                    if (code[0]) begin
                        next[a*color_w +: color_w] = cube[b*color_w +: color_w];
                    end else begin
                        next[b*color_w +: color_w] = cube[a*color_w +: color_w];
                    end
                end
            end
        end
        return next;
    endfunction

    function automatic cube_state_t apply_move_list(input cube_state_t cube,
                                                    input move_list_t list);
        cube_state_t result;
        result = cube;
        for (int i = 0; i < move_count; i++) begin
            result = turn_reference(result, list[$bits(move_list_t)-1 - move_w*i -: move_w]);
        end
        return result;
    endfunction

    task automatic add_row(input move_list_t list, input bit use_random, input bit identity);
        tab_moves.push_back(list);
        tab_random.push_back(use_random);
        tab_identity.push_back(identity);
        seq_q.delete();
    endtask

    task automatic build_table();
        logic [3:0] cw;
        // the named no-op and the three unnamed codes
        for (int i = 0; i < move_count; i++) begin
            case (i % 4)
                0:       seq_q.push_back(4'd0);
                1:       seq_q.push_back(4'd1);
                2:       seq_q.push_back(4'd14);
                default: seq_q.push_back(4'd15);
            endcase
        end
        add_row(pack_moves(), 1'b0, 1'b1);
        // per face: turn and inverse, then four of each direction
        for (int f = 0; f < face_count; f++) begin
            cw = 4'(2 + 2 * f);
            seq_q.push_back(cw);
            seq_q.push_back(cw + 4'd1);
            repeat (4) seq_q.push_back(cw);
            repeat (4) seq_q.push_back(cw + 4'd1);
            add_row(pack_moves(), 1'b1, 1'b1);
        end
        for (int c = 2; c < 14; c++) begin
            seq_q.push_back(4'(c));
            add_row(pack_moves(), 1'b1, 1'b0);
        end
        // R U Ri Ui has order six
        repeat (6) begin
            seq_q.push_back(4'(mv_r));
            seq_q.push_back(4'(mv_u));
            seq_q.push_back(4'(mv_ri));
            seq_q.push_back(4'(mv_ui));
        end
        add_row(pack_moves(), 1'b1, 1'b1);
        add_row(random_moves(), 1'b1, 1'b0);
        n_rows = tab_moves.size();
        table_ready = 1'b1;
    endtask

    // entered on a falling edge, returns on the falling edge after edge 52
    task automatic run_job(input int row);
        cube_state_t start;
        cube_state_t expected;
        if (tab_random[row]) begin
            start = random_cube();
        end else begin
            start = pattern_cube();
        end
        if (tab_identity[row]) begin
            expected = start;
        end else begin
            expected = apply_move_list(start, tab_moves[row]);
        end
        moves_input     = tab_moves[row];
        cubestate_input = start;
        new_moves_ready = 1'b1;
        for (int n = 0; n <= 52; n++) begin
            @(negedge clock);
            new_moves_ready = 1'b0;
            cubestate_input = ~start;
            if (n == 20) begin
                // second strobe in the middle of the job
                new_moves_ready = 1'b1;
                moves_input     = random_moves();
                cubestate_input = random_cube();
            end
            check_bit("state_updated", n == 51, state_updated);
            if (n < 51) begin
                check_cube("cubestate_updated", last_result, cubestate_updated);
            end else begin
                check_cube("cubestate_updated", expected, cubestate_updated);
            end
        end
        last_result = expected;
    endtask

    initial begin
        seed            = 32'h7907;
        clock           = 1'b0;
        rst             = 1'b1;
        new_moves_ready = 1'b0;
        moves_input     = '0;
        cubestate_input = '0;
        last_result     = '0;
        table_ready     = 1'b0;
        build_table();
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        repeat (3) begin
            @(negedge clock);
            check_bit("state_updated", 1'b0, state_updated);
            check_cube("cubestate_updated", '0, cubestate_updated);
        end
        for (int row = 0; row < n_rows; row++) begin
            run_job(row);
        end
        $display("** PASS **");
        $finish;
    end

    initial begin
        wait (table_ready);
        #((n_rows + 2) * job_cycles * clk_period);
        $display("timeout: the jobs did not complete within the expected time");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* sim.f */
src/cube_pkg.sv
src/move_pkg.sv
src/move_sequencer.sv
src/cube_turner.sv
src/cube_move_engine.sv
test/cube_move_engine_properties.sv
test/tb_cube_move_engine.sv

/* Makefile */
SIM := obj_dir/Vtb_cube_move_engine

.PHONY: all run clean

all: run

$(SIM): sim.f $(wildcard src/*.sv) $(wildcard test/*.sv)
	verilator --binary --assert -Wno-fatal --top-module tb_cube_move_engine -f sim.f

run: $(SIM)
	-$(SIM) 2>&1 | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log || ! grep -q '\*\* PASS \*\*' sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
